/* tlb_cfg_pkg.sv */
`default_nettype none

package tlb_cfg_pkg;

    // ------------------------------------------------------------
    // entry field widths
    // ------------------------------------------------------------

    // virtual page-pair number, va[31:13].
    localparam int unsigned vppn_w = 19;
    localparam int unsigned asid_w = 10;
    localparam int unsigned ppn_w  = 20;
    localparam int unsigned plv_w  = 2;
    localparam int unsigned mat_w  = 2;

    // ------------------------------------------------------------
    // page-size codes
    // ------------------------------------------------------------

    localparam int unsigned ps_w = 6;

    // log2 of the page size in bytes.
    localparam logic [ps_w-1:0] ps_4k = 6'd12;
    localparam logic [ps_w-1:0] ps_4m = 6'd22;

    // ------------------------------------------------------------
    // vppn bit positions for 4 MB pairs
    // ------------------------------------------------------------

    // picks the odd half of a 4 MB pair.
    localparam int unsigned huge_split_bit = 9;

    // lowest vppn bit compared for a 4 MB entry.
    localparam int unsigned huge_cmp_lsb = 10;

endpackage

`default_nettype wire

/* tlb_op_pkg.sv */
`default_nettype none

package tlb_op_pkg;

    // ------------------------------------------------------------
    // invtlb opcodes
    // ------------------------------------------------------------

    // codes above 6 leave the tlb unchanged.
    typedef enum logic [4:0] {
        // clear every entry.
        inv_all0    = 5'd0,
        inv_all1    = 5'd1,
        // clear global entries.
        inv_glob    = 5'd2,
        // clear non-global entries.
        inv_nonglob = 5'd3,
        // non-global entries with an asid match.
        inv_asid    = 5'd4,
        // non-global entries with asid and va match.
        inv_asid_va = 5'd5,
        // va match on global or asid-matched entries.
        inv_va      = 5'd6
    } invtlb_op_e;

endpackage

`default_nettype wire

/* tlb_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_lookup #(
    parameter int TLBNUM = 16
) (
    input  wire logic [tlb_cfg_pkg::vppn_w-1:0]           vppn,
    input  wire logic                                     va_bit12,
    input  wire logic [tlb_cfg_pkg::asid_w-1:0]           asid,
    input  wire logic [TLBNUM-1:0]                        ent_e,
    input  wire logic [TLBNUM-1:0]                        ent_g,
    input  wire logic [TLBNUM-1:0]                        ent_huge,
    input  wire logic [TLBNUM-1:0][tlb_cfg_pkg::vppn_w-1:0] ent_vppn,
    input  wire logic [TLBNUM-1:0][tlb_cfg_pkg::asid_w-1:0] ent_asid,
    input  wire logic [TLBNUM-1:0][tlb_cfg_pkg::ppn_w-1:0]  ent_ppn0,
    input  wire logic [TLBNUM-1:0][tlb_cfg_pkg::ppn_w-1:0]  ent_ppn1,
    input  wire logic [TLBNUM-1:0][tlb_cfg_pkg::plv_w-1:0]  ent_plv0,
    input  wire logic [TLBNUM-1:0][tlb_cfg_pkg::plv_w-1:0]  ent_plv1,
    input  wire logic [TLBNUM-1:0][tlb_cfg_pkg::mat_w-1:0]  ent_mat0,
    input  wire logic [TLBNUM-1:0][tlb_cfg_pkg::mat_w-1:0]  ent_mat1,
    input  wire logic [TLBNUM-1:0]                        ent_d0,
    input  wire logic [TLBNUM-1:0]                        ent_d1,
    input  wire logic [TLBNUM-1:0]                        ent_v0,
    input  wire logic [TLBNUM-1:0]                        ent_v1,
    output logic                                          found,
    output logic [$clog2(TLBNUM)-1:0]                     index,
    output logic [tlb_cfg_pkg::ppn_w-1:0]                 ppn,
    output logic [tlb_cfg_pkg::ps_w-1:0]                  ps,
    output logic [tlb_cfg_pkg::plv_w-1:0]                 plv,
    output logic [tlb_cfg_pkg::mat_w-1:0]                 mat,
    output logic                                          d,
    output logic                                          v
);

    localparam int IDX_W = $clog2(TLBNUM);
    localparam int HI    = tlb_cfg_pkg::vppn_w - 1;
    localparam int LSB   = tlb_cfg_pkg::huge_cmp_lsb;

    logic [TLBNUM-1:0] match;
    logic              hit_huge;
    logic              odd;

    // ------------------------------------------------------------
    // match vector
    // ------------------------------------------------------------

    // low vppn half ignored for 4 MB entries.
    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            match[i] = ent_e[i] &&
                       (ent_g[i] || ent_asid[i] == asid) &&
                       (vppn[HI:LSB] == ent_vppn[i][HI:LSB]) &&
                       (ent_huge[i] || vppn[LSB-1:0] == ent_vppn[i][LSB-1:0]);
        end
    end

    assign found = |match;

    // lowest index wins.
    always_comb begin
        index = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                index = IDX_W'(i);
            end
        end
    end

    // ------------------------------------------------------------
    // page-half select
    // ------------------------------------------------------------

    assign hit_huge = found && ent_huge[index];
    assign odd      = hit_huge ? vppn[tlb_cfg_pkg::huge_split_bit] : va_bit12;

    always_comb begin
        ppn = '0;
        ps  = '0;
        plv = '0;
        mat = '0;
        d   = 1'b0;
        v   = 1'b0;
        if (found) begin
            ps = hit_huge ? tlb_cfg_pkg::ps_4m : tlb_cfg_pkg::ps_4k;
            if (odd) begin
                ppn = ent_ppn1[index];
                plv = ent_plv1[index];
                mat = ent_mat1[index];
                d   = ent_d1[index];
                v   = ent_v1[index];
            end else begin
                ppn = ent_ppn0[index];
                plv = ent_plv0[index];
                mat = ent_mat0[index];
                d   = ent_d0[index];
                v   = ent_v0[index];
            end
        end
    end

endmodule

`default_nettype wire

/* tlb_entry_array.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_entry_array #(
    parameter int TLBNUM = 16
) (
    input  wire logic                                     clk,
    input  wire logic                                     reset,
    // write port
    input  wire logic                                     we,
    input  wire logic [$clog2(TLBNUM)-1:0]                w_index,
    input  wire logic                                     w_e,
    input  wire logic [tlb_cfg_pkg::vppn_w-1:0]           w_vppn,
    input  wire logic [tlb_cfg_pkg::ps_w-1:0]             w_ps,
    input  wire logic [tlb_cfg_pkg::asid_w-1:0]           w_asid,
    input  wire logic                                     w_g,
    input  wire logic [tlb_cfg_pkg::ppn_w-1:0]            w_ppn0,
    input  wire logic [tlb_cfg_pkg::plv_w-1:0]            w_plv0,
    input  wire logic [tlb_cfg_pkg::mat_w-1:0]            w_mat0,
    input  wire logic                                     w_d0,
    input  wire logic                                     w_v0,
    input  wire logic [tlb_cfg_pkg::ppn_w-1:0]            w_ppn1,
    input  wire logic [tlb_cfg_pkg::plv_w-1:0]            w_plv1,
    input  wire logic [tlb_cfg_pkg::mat_w-1:0]            w_mat1,
    input  wire logic                                     w_d1,
    input  wire logic                                     w_v1,
    // invalidate
    input  wire logic                                     inv,
    input  wire tlb_op_pkg::invtlb_op_e                   inv_op,
    input  wire logic [tlb_cfg_pkg::asid_w-1:0]           inv_asid,
    input  wire logic [tlb_cfg_pkg::vppn_w-1:0]           inv_vppn,
    // read port
    input  wire logic [$clog2(TLBNUM)-1:0]                r_index,
    output logic                                          r_e,
    output logic [tlb_cfg_pkg::vppn_w-1:0]                r_vppn,
    output logic [tlb_cfg_pkg::ps_w-1:0]                  r_ps,
    output logic [tlb_cfg_pkg::asid_w-1:0]                r_asid,
    output logic                                          r_g,
    output logic [tlb_cfg_pkg::ppn_w-1:0]                 r_ppn0,
    output logic [tlb_cfg_pkg::plv_w-1:0]                 r_plv0,
    output logic [tlb_cfg_pkg::mat_w-1:0]                 r_mat0,
    output logic                                          r_d0,
    output logic                                          r_v0,
    output logic [tlb_cfg_pkg::ppn_w-1:0]                 r_ppn1,
    output logic [tlb_cfg_pkg::plv_w-1:0]                 r_plv1,
    output logic [tlb_cfg_pkg::mat_w-1:0]                 r_mat1,
    output logic                                          r_d1,
    output logic                                          r_v1,
    // lookup results
    input  wire logic                                     s0_found,
    input  wire logic [$clog2(TLBNUM)-1:0]                s0_index,
    input  wire logic                                     s1_found,
    input  wire logic [$clog2(TLBNUM)-1:0]                s1_index,
    output logic                                          stale_hit,
    // committed entry state
    output logic [TLBNUM-1:0]                             ent_e,
    output logic [TLBNUM-1:0]                             ent_g,
    output logic [TLBNUM-1:0]                             ent_huge,
    output logic [TLBNUM-1:0][tlb_cfg_pkg::vppn_w-1:0]    ent_vppn,
    output logic [TLBNUM-1:0][tlb_cfg_pkg::asid_w-1:0]    ent_asid,
    output logic [TLBNUM-1:0][tlb_cfg_pkg::ppn_w-1:0]     ent_ppn0,
    output logic [TLBNUM-1:0][tlb_cfg_pkg::ppn_w-1:0]     ent_ppn1,
    output logic [TLBNUM-1:0][tlb_cfg_pkg::plv_w-1:0]     ent_plv0,
    output logic [TLBNUM-1:0][tlb_cfg_pkg::plv_w-1:0]     ent_plv1,
    output logic [TLBNUM-1:0][tlb_cfg_pkg::mat_w-1:0]     ent_mat0,
    output logic [TLBNUM-1:0][tlb_cfg_pkg::mat_w-1:0]     ent_mat1,
    output logic [TLBNUM-1:0]                             ent_d0,
    output logic [TLBNUM-1:0]                             ent_d1,
    output logic [TLBNUM-1:0]                             ent_v0,
    output logic [TLBNUM-1:0]                             ent_v1
);

    localparam int HI  = tlb_cfg_pkg::vppn_w - 1;
    localparam int LSB = tlb_cfg_pkg::huge_cmp_lsb;

    logic [TLBNUM-1:0] va_match;
    logic [TLBNUM-1:0] asid_match;
    logic [TLBNUM-1:0] clr_cond;
    logic [TLBNUM-1:0] clr_mask;
    logic              s0_stale;
    logic              s1_stale;

    // ------------------------------------------------------------
    // invtlb decode
    // ------------------------------------------------------------

    // same va rule as a search.
    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            va_match[i] = (inv_vppn[HI:LSB] == ent_vppn[i][HI:LSB]) &&
                          (ent_huge[i] || inv_vppn[LSB-1:0] == ent_vppn[i][LSB-1:0]);
            asid_match[i] = (inv_asid == ent_asid[i]);
        end
    end

    always_comb begin
        case (inv_op)
            tlb_op_pkg::inv_all0,
            tlb_op_pkg::inv_all1:    clr_cond = '1;
            tlb_op_pkg::inv_glob:    clr_cond = ent_g;
            tlb_op_pkg::inv_nonglob: clr_cond = ~ent_g;
            tlb_op_pkg::inv_asid:    clr_cond = ~ent_g & asid_match;
            tlb_op_pkg::inv_asid_va: clr_cond = ~ent_g & asid_match & va_match;
            tlb_op_pkg::inv_va:      clr_cond = (ent_g | asid_match) & va_match;
            default:                 clr_cond = '0;
        endcase
    end

    assign clr_mask = {TLBNUM{inv}} & clr_cond;

    // ------------------------------------------------------------
    // entry update
    // ------------------------------------------------------------

    // invalidate first, then the write.
    always_ff @(posedge clk) begin
        if (reset) begin
            ent_e <= '0;
        end else begin
            ent_e <= ent_e & ~clr_mask;
            if (we) begin
                ent_e[w_index] <= w_e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ent_vppn[w_index] <= w_vppn;
            ent_asid[w_index] <= w_asid;
            ent_g[w_index]    <= w_g;
            ent_huge[w_index] <= (w_ps == tlb_cfg_pkg::ps_4m);
            ent_ppn0[w_index] <= w_ppn0;
            ent_plv0[w_index] <= w_plv0;
            ent_mat0[w_index] <= w_mat0;
            ent_d0[w_index]   <= w_d0;
            ent_v0[w_index]   <= w_v0;
            ent_ppn1[w_index] <= w_ppn1;
            ent_plv1[w_index] <= w_plv1;
            ent_mat1[w_index] <= w_mat1;
            ent_d1[w_index]   <= w_d1;
            ent_v1[w_index]   <= w_v1;
        end
    end

    // ------------------------------------------------------------
    // read port and stale-hit detection
    // ------------------------------------------------------------

    assign r_e    = ent_e[r_index];
    assign r_vppn = ent_vppn[r_index];
    assign r_ps   = ent_huge[r_index] ? tlb_cfg_pkg::ps_4m : tlb_cfg_pkg::ps_4k;
    assign r_asid = ent_asid[r_index];
    assign r_g    = ent_g[r_index];
    assign r_ppn0 = ent_ppn0[r_index];
    assign r_plv0 = ent_plv0[r_index];
    assign r_mat0 = ent_mat0[r_index];
    assign r_d0   = ent_d0[r_index];
    assign r_v0   = ent_v0[r_index];
    assign r_ppn1 = ent_ppn1[r_index];
    assign r_plv1 = ent_plv1[r_index];
    assign r_mat1 = ent_mat1[r_index];
    assign r_d1   = ent_d1[r_index];
    assign r_v1   = ent_v1[r_index];

    // a hit on an entry that changes at the coming edge.
    assign s0_stale = s0_found && ((we && s0_index == w_index) || clr_mask[s0_index]);
    assign s1_stale = s1_found && ((we && s1_index == w_index) || clr_mask[s1_index]);

    assign stale_hit = s0_stale || s1_stale;

endmodule

`default_nettype wire

/* tlb.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb #(
    parameter int TLBNUM = 16
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    // search port 0 for instruction fetch
    input  wire logic [tlb_cfg_pkg::vppn_w-1:0]      s0_vppn,
    input  wire logic                                s0_va_bit12,
    input  wire logic [tlb_cfg_pkg::asid_w-1:0]      s0_asid,
    output logic                                     s0_found,
    output logic [$clog2(TLBNUM)-1:0]                s0_index,
    output logic [tlb_cfg_pkg::ppn_w-1:0]            s0_ppn,
    output logic [tlb_cfg_pkg::ps_w-1:0]             s0_ps,
    output logic [tlb_cfg_pkg::plv_w-1:0]            s0_plv,
    output logic [tlb_cfg_pkg::mat_w-1:0]            s0_mat,
    output logic                                     s0_d,
    output logic                                     s0_v,
    // search port 1 for loads and stores
    input  wire logic [tlb_cfg_pkg::vppn_w-1:0]      s1_vppn,
    input  wire logic                                s1_va_bit12,
    input  wire logic [tlb_cfg_pkg::asid_w-1:0]      s1_asid,
    output logic                                     s1_found,
    output logic [$clog2(TLBNUM)-1:0]                s1_index,
    output logic [tlb_cfg_pkg::ppn_w-1:0]            s1_ppn,
    output logic [tlb_cfg_pkg::ps_w-1:0]             s1_ps,
    output logic [tlb_cfg_pkg::plv_w-1:0]            s1_plv,
    output logic [tlb_cfg_pkg::mat_w-1:0]            s1_mat,
    output logic                                     s1_d,
    output logic                                     s1_v,
    // write port
    input  wire logic                                we,
    input  wire logic [$clog2(TLBNUM)-1:0]           w_index,
    input  wire logic                                w_e,
    input  wire logic [tlb_cfg_pkg::vppn_w-1:0]      w_vppn,
    input  wire logic [tlb_cfg_pkg::ps_w-1:0]        w_ps,
    input  wire logic [tlb_cfg_pkg::asid_w-1:0]      w_asid,
    input  wire logic                                w_g,
    input  wire logic [tlb_cfg_pkg::ppn_w-1:0]       w_ppn0,
    input  wire logic [tlb_cfg_pkg::plv_w-1:0]       w_plv0,
    input  wire logic [tlb_cfg_pkg::mat_w-1:0]       w_mat0,
    input  wire logic                                w_d0,
    input  wire logic                                w_v0,
    input  wire logic [tlb_cfg_pkg::ppn_w-1:0]       w_ppn1,
    input  wire logic [tlb_cfg_pkg::plv_w-1:0]       w_plv1,
    input  wire logic [tlb_cfg_pkg::mat_w-1:0]       w_mat1,
    input  wire logic                                w_d1,
    input  wire logic                                w_v1,
    // invtlb
    input  wire logic                                inv,
    input  wire tlb_op_pkg::invtlb_op_e              inv_op,
    input  wire logic [tlb_cfg_pkg::asid_w-1:0]      inv_asid,
    input  wire logic [tlb_cfg_pkg::vppn_w-1:0]      inv_vppn,
    // read port
    input  wire logic [$clog2(TLBNUM)-1:0]           r_index,
    output logic                                     r_e,
    output logic [tlb_cfg_pkg::vppn_w-1:0]           r_vppn,
    output logic [tlb_cfg_pkg::ps_w-1:0]             r_ps,
    output logic [tlb_cfg_pkg::asid_w-1:0]           r_asid,
    output logic                                     r_g,
    output logic [tlb_cfg_pkg::ppn_w-1:0]            r_ppn0,
    output logic [tlb_cfg_pkg::plv_w-1:0]            r_plv0,
    output logic [tlb_cfg_pkg::mat_w-1:0]            r_mat0,
    output logic                                     r_d0,
    output logic                                     r_v0,
    output logic [tlb_cfg_pkg::ppn_w-1:0]            r_ppn1,
    output logic [tlb_cfg_pkg::plv_w-1:0]            r_plv1,
    output logic [tlb_cfg_pkg::mat_w-1:0]            r_mat1,
    output logic                                     r_d1,
    output logic                                     r_v1,
    // replay request to the core
    output logic                                     stale_hit
);

    // shared entry state seen by both lookups.
    logic [TLBNUM-1:0]                          ent_e;
    logic [TLBNUM-1:0]                          ent_g;
    logic [TLBNUM-1:0]                          ent_huge;
    logic [TLBNUM-1:0][tlb_cfg_pkg::vppn_w-1:0] ent_vppn;
    logic [TLBNUM-1:0][tlb_cfg_pkg::asid_w-1:0] ent_asid;
    logic [TLBNUM-1:0][tlb_cfg_pkg::ppn_w-1:0]  ent_ppn0;
    logic [TLBNUM-1:0][tlb_cfg_pkg::ppn_w-1:0]  ent_ppn1;
    logic [TLBNUM-1:0][tlb_cfg_pkg::plv_w-1:0]  ent_plv0;
    logic [TLBNUM-1:0][tlb_cfg_pkg::plv_w-1:0]  ent_plv1;
    logic [TLBNUM-1:0][tlb_cfg_pkg::mat_w-1:0]  ent_mat0;
    logic [TLBNUM-1:0][tlb_cfg_pkg::mat_w-1:0]  ent_mat1;
    logic [TLBNUM-1:0]                          ent_d0;
    logic [TLBNUM-1:0]                          ent_d1;
    logic [TLBNUM-1:0]                          ent_v0;
    logic [TLBNUM-1:0]                          ent_v1;

    // port names match the top level one to one.
    tlb_entry_array #(.TLBNUM(TLBNUM)) entries0 (.*);

    tlb_lookup #(.TLBNUM(TLBNUM)) fetch_lookup0 (
        .vppn(s0_vppn), .va_bit12(s0_va_bit12), .asid(s0_asid),
        .ent_e, .ent_g, .ent_huge, .ent_vppn, .ent_asid,
        .ent_ppn0, .ent_ppn1, .ent_plv0, .ent_plv1, .ent_mat0, .ent_mat1,
        .ent_d0, .ent_d1, .ent_v0, .ent_v1,
        .found(s0_found), .index(s0_index), .ppn(s0_ppn), .ps(s0_ps),
        .plv(s0_plv), .mat(s0_mat), .d(s0_d), .v(s0_v)
    );

    tlb_lookup #(.TLBNUM(TLBNUM)) mem_lookup0 (
        .vppn(s1_vppn), .va_bit12(s1_va_bit12), .asid(s1_asid),
        .ent_e, .ent_g, .ent_huge, .ent_vppn, .ent_asid,
        .ent_ppn0, .ent_ppn1, .ent_plv0, .ent_plv1, .ent_mat0, .ent_mat1,
        .ent_d0, .ent_d1, .ent_v0, .ent_v1,
        .found(s1_found), .index(s1_index), .ppn(s1_ppn), .ps(s1_ps),
        .plv(s1_plv), .mat(s1_mat), .d(s1_d), .v(s1_v)
    );

endmodule

`default_nettype wire

/* tlb_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_chk (
    input wire logic                         clk,
    input wire logic                         reset,
    input wire logic                         s0_found,
    input wire logic                         s1_found,
    input wire logic [tlb_cfg_pkg::ps_w-1:0] r_ps,
    input wire logic                         stale_hit,
    input wire logic                         we,
    input wire logic                         inv
);

    // ------------------------------------------------------------
    // reset clears every entry
    // ------------------------------------------------------------

    no_hit_after_reset: assert property (
        @(posedge clk) $past(reset) |-> !s0_found && !s1_found
    ) else $error("lookup hit right after a reset cycle");

    // ------------------------------------------------------------
    // read port and replay flag
    // ------------------------------------------------------------

    // only two page sizes exist.
    legal_read_ps: assert property (
        @(posedge clk) disable iff (reset)
        r_ps == tlb_cfg_pkg::ps_4k || r_ps == tlb_cfg_pkg::ps_4m
    ) else $error("read port page size is neither 4 KB nor 4 MB");

    stale_needs_update: assert property (
        @(posedge clk) disable iff (reset)
        stale_hit |-> we || inv
    ) else $error("stale_hit raised with no write or invalidate pending");

endmodule

`default_nettype wire

/* tb_tlb.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_tlb;

    localparam int TLBNUM = 16;
    localparam int idx_w = $clog2(TLBNUM);
    localparam int vppn_w = tlb_cfg_pkg::vppn_w;
    localparam int asid_w = tlb_cfg_pkg::asid_w;
    localparam int ppn_w = tlb_cfg_pkg::ppn_w;
    localparam int ps_w = tlb_cfg_pkg::ps_w;
    localparam int lsb = tlb_cfg_pkg::huge_cmp_lsb;
    localparam int reset_cycles = 2;
    localparam int fill_cycles = 300;
    localparam int rand_cycles = 2980;
    localparam int test_cycles = reset_cycles + TLBNUM + rand_cycles;
    localparam int max_cycles = test_cycles + test_cycles / 3;

    logic clk, reset, we, w_e, w_g, inv, stale_hit;
    logic s0_va_bit12, s0_found, s0_d, s0_v, s1_va_bit12, s1_found, s1_d, s1_v;
    logic w_d0, w_v0, w_d1, w_v1, r_e, r_g, r_d0, r_v0, r_d1, r_v1;
    logic [idx_w-1:0] s0_index, s1_index, w_index, r_index;
    logic [vppn_w-1:0] s0_vppn, s1_vppn, w_vppn, inv_vppn, r_vppn;
    logic [asid_w-1:0] s0_asid, s1_asid, w_asid, inv_asid, r_asid;
    logic [ppn_w-1:0] s0_ppn, s1_ppn, w_ppn0, w_ppn1, r_ppn0, r_ppn1;
    logic [ps_w-1:0] s0_ps, s1_ps, w_ps, r_ps;
    logic [1:0] s0_plv, s0_mat, s1_plv, s1_mat, w_plv0, w_mat0, w_plv1, w_mat1;
    logic [1:0] r_plv0, r_mat0, r_plv1, r_mat1;
    tlb_op_pkg::invtlb_op_e inv_op;

    // reference model of the entries.
    logic m_e [TLBNUM];
    logic m_written [TLBNUM];
    logic m_g [TLBNUM];
    logic m_huge [TLBNUM];
    logic [vppn_w-1:0] m_vppn [TLBNUM];
    logic [asid_w-1:0] m_asid [TLBNUM];
    logic [ppn_w-1:0] m_ppn [TLBNUM][2];
    logic [1:0] m_plv [TLBNUM][2];
    logic [1:0] m_mat [TLBNUM][2];
    logic m_d [TLBNUM][2];
    logic m_v [TLBNUM][2];

    // small key pools; several pairs share the 4 MB compare bits.
    logic [vppn_w-1:0] vppn_pool [6] = '{19'h2a5c3, 19'h2a5c2, 19'h2a7c3,
                                         19'h2a43c, 19'h51e80, 19'h51c80};
    logic [asid_w-1:0] asid_pool [3] = '{10'h001, 10'h2c5, 10'h3ff};

    string test_name;
    int err_count = 0;
    int cycles = 0;

    tlb #(.TLBNUM(TLBNUM)) dut0 (.*);

    bind tlb tlb_chk chk0 (.clk(clk), .reset(reset), .s0_found(s0_found),
        .s1_found(s1_found), .r_ps(r_ps), .stale_hit(stale_hit), .we(we), .inv(inv));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= max_cycles) begin
                $display("timeout: no end of test after %0d cycles", max_cycles);
                $display("Simulation failed");
                $fatal(1);
            end
        end
    end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            err_count++;
            $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic logic [vppn_w-1:0] pick_vppn();
        logic [vppn_w-1:0] v;
        int unsigned rnd;
        v = vppn_pool[$urandom_range(0, 5)];
        rnd = $urandom;
        // sometimes scramble the low half, which a 4 MB entry ignores.
        if (rnd[1:0] == 2'd0) begin
            v[lsb-1:0] = rnd[lsb+1:2];
        end
        return v;
    endfunction

    function automatic logic va_match(input logic [vppn_w-1:0] vppn, input int i);
        if (vppn[vppn_w-1:lsb] != m_vppn[i][vppn_w-1:lsb]) begin
            return 1'b0;
        end
        return m_huge[i] || vppn[lsb-1:0] == m_vppn[i][lsb-1:0];
    endfunction

    function automatic logic inv_clears(input int i);
        logic asid_eq;
        asid_eq = (m_asid[i] == inv_asid);
        case (inv_op)
            tlb_op_pkg::inv_all0, tlb_op_pkg::inv_all1: return 1'b1;
            tlb_op_pkg::inv_glob: return m_g[i];
            tlb_op_pkg::inv_nonglob: return !m_g[i];
            tlb_op_pkg::inv_asid: return !m_g[i] && asid_eq;
            tlb_op_pkg::inv_asid_va: return !m_g[i] && asid_eq && va_match(inv_vppn, i);
            tlb_op_pkg::inv_va: return (m_g[i] || asid_eq) && va_match(inv_vppn, i);
            default: return 1'b0;
        endcase
    endfunction

    // lowest valid entry matching the key, or -1.
    function automatic int model_hit(input logic [vppn_w-1:0] vppn, input logic [asid_w-1:0] asid);
        int hit;
        hit = -1;
        for (int i = 0; i < TLBNUM; i++) begin
            if (hit < 0 && m_e[i] && (m_g[i] || m_asid[i] == asid) && va_match(vppn, i)) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    function automatic logic touched(input int hit);
        return hit >= 0 && ((we && hit == int'(w_index)) || (inv && inv_clears(hit)));
    endfunction

    task automatic check_port(input string port, input logic [vppn_w-1:0] vppn,
        input logic bit12, input logic [asid_w-1:0] asid, input logic a_found,
        input logic [idx_w-1:0] a_index, input logic [ppn_w-1:0] a_ppn,
        input logic [ps_w-1:0] a_ps, input logic [1:0] a_plv, input logic [1:0] a_mat,
        input logic a_d, input logic a_v, output int hit);
        int h;
        hit = model_hit(vppn, asid);
        check_val({port, "_found"}, 32'(hit >= 0), 32'(a_found));
        if (hit < 0) begin
            check_val({port, "_index"}, 32'd0, 32'(a_index));
            check_val({port, "_ppn"}, 32'd0, 32'(a_ppn));
            check_val({port, "_attr"}, 32'd0, 32'({a_ps, a_plv, a_mat, a_d, a_v}));
        end else begin
            // odd page by vppn bit 9 for 4 MB, by va bit 12 for 4 KB.
            h = m_huge[hit] ? int'(vppn[tlb_cfg_pkg::huge_split_bit]) : int'(bit12);
            check_val({port, "_index"}, 32'(hit), 32'(a_index));
            check_val({port, "_ps"}, m_huge[hit] ? 32'd22 : 32'd12, 32'(a_ps));
            check_val({port, "_ppn"}, 32'(m_ppn[hit][h]), 32'(a_ppn));
            check_val({port, "_plv"}, 32'(m_plv[hit][h]), 32'(a_plv));
            check_val({port, "_mat"}, 32'(m_mat[hit][h]), 32'(a_mat));
            check_val({port, "_d"}, 32'(m_d[hit][h]), 32'(a_d));
            check_val({port, "_v"}, 32'(m_v[hit][h]), 32'(a_v));
        end
    endtask

    task automatic check_cycle();
        int hit0;
        int hit1;
        check_port("s0", s0_vppn, s0_va_bit12, s0_asid, s0_found, s0_index, s0_ppn,
                   s0_ps, s0_plv, s0_mat, s0_d, s0_v, hit0);
        check_port("s1", s1_vppn, s1_va_bit12, s1_asid, s1_found, s1_index, s1_ppn,
                   s1_ps, s1_plv, s1_mat, s1_d, s1_v, hit1);
        check_val("stale_hit", 32'(touched(hit0) || touched(hit1)), 32'(stale_hit));
        check_val("r_e", 32'(m_e[r_index]), 32'(r_e));
        // fields of a never-written entry are undefined.
        if (m_written[r_index]) begin
            check_val("r_vppn", 32'(m_vppn[r_index]), 32'(r_vppn));
            check_val("r_ps", m_huge[r_index] ? 32'd22 : 32'd12, 32'(r_ps));
            check_val("r_asid", 32'(m_asid[r_index]), 32'(r_asid));
            check_val("r_g", 32'(m_g[r_index]), 32'(r_g));
            check_val("r_ppn0", 32'(m_ppn[r_index][0]), 32'(r_ppn0));
            check_val("r_ppn1", 32'(m_ppn[r_index][1]), 32'(r_ppn1));
            check_val("r_page0", 32'({m_plv[r_index][0], m_mat[r_index][0], m_d[r_index][0],
                      m_v[r_index][0]}), 32'({r_plv0, r_mat0, r_d0, r_v0}));
            check_val("r_page1", 32'({m_plv[r_index][1], m_mat[r_index][1], m_d[r_index][1],
                      m_v[r_index][1]}), 32'({r_plv1, r_mat1, r_d1, r_v1}));
        end
    endtask

    // invalidate first, then the write.
    task automatic update_model();
        int w;
        w = int'(w_index);
        if (inv) begin
            for (int i = 0; i < TLBNUM; i++) begin
                if (inv_clears(i)) begin
                    m_e[i] = 1'b0;
                end
            end
        end
        if (we) begin
            m_e[w] = w_e;
            m_written[w] = 1'b1;
            m_vppn[w] = w_vppn;
            m_asid[w] = w_asid;
            m_g[w] = w_g;
            m_huge[w] = (w_ps == tlb_cfg_pkg::ps_4m);
            m_ppn[w] = '{w_ppn0, w_ppn1};
            m_plv[w] = '{w_plv0, w_plv1};
            m_mat[w] = '{w_mat0, w_mat1};
            m_d[w] = '{w_d0, w_d1};
            m_v[w] = '{w_v0, w_v1};
        end
    endtask

    task automatic drive_idle();
        {we, w_e, w_g, inv, s0_va_bit12, s1_va_bit12} = '0;
        {w_d0, w_v0, w_d1, w_v1, w_plv0, w_mat0, w_plv1, w_mat1} = '0;
        {w_index, r_index, w_ppn0, w_ppn1, w_ps} = '0;
        {s0_vppn, s1_vppn, w_vppn, inv_vppn} = '0;
        {s0_asid, s1_asid, w_asid, inv_asid} = '0;
        inv_op = tlb_op_pkg::inv_all0;
    endtask

    task automatic drive_random(input int c);
        int unsigned rnd;
        rnd = $urandom;
        we = (c < fill_cycles) ? rnd[1:0] != 2'd0 : rnd[2:0] < 3'd2;
        inv = (c < fill_cycles) ? 1'b0 : rnd[6:3] < 4'd2;
        w_index = rnd[8 +: idx_w];
        w_e = rnd[15:13] != 3'd0;
        w_ps = rnd[16] ? tlb_cfg_pkg::ps_4m : tlb_cfg_pkg::ps_4k;
        w_g = rnd[18:17] == 2'd0;
        {w_plv0, w_mat0, w_d0, w_v0} = rnd[24:19];
        {w_plv1, w_mat1, w_d1, w_v1} = rnd[30:25];
        s0_va_bit12 = rnd[31];
        rnd = $urandom;
        w_ppn0 = rnd[ppn_w-1:0];
        r_index = rnd[26 +: idx_w];
        s1_va_bit12 = rnd[31];
        rnd = $urandom;
        w_ppn1 = rnd[ppn_w-1:0];
        inv_op = tlb_op_pkg::invtlb_op_e'(5'(rnd[31:24] % 8'd10));
        {w_vppn, s0_vppn, s1_vppn, inv_vppn} = {pick_vppn(), pick_vppn(), pick_vppn(), pick_vppn()};
        w_asid = asid_pool[$urandom_range(0, 2)];
        s0_asid = asid_pool[$urandom_range(0, 2)];
        s1_asid = asid_pool[$urandom_range(0, 2)];
        inv_asid = asid_pool[$urandom_range(0, 2)];
    endtask

    initial begin
        void'($urandom(95));
        drive_idle();
        reset = 1'b1;
        for (int i = 0; i < TLBNUM; i++) begin
            m_e[i] = 1'b0;
            m_written[i] = 1'b0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name = "reset_sweep";
        for (int i = 0; i < TLBNUM; i++) begin
            @(negedge clk);
            r_index = idx_w'(i);
            s0_vppn = pick_vppn();
            s1_vppn = pick_vppn();
            #1;
            check_cycle();
        end

        for (int c = 0; c < rand_cycles; c++) begin
            @(negedge clk);
            test_name = (c < fill_cycles) ? "fill" : "mixed";
            drive_random(c);
            #1;
            check_cycle();
            update_model();
        end

        @(negedge clk);
        drive_idle();
        if (err_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* tlb.f */
tlb_cfg_pkg.sv
tlb_op_pkg.sv
tlb_lookup.sv
tlb_entry_array.sv
tlb.sv
tlb_chk.sv
tb_tlb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_tlb -f tlb.f -o tb_tlb

output=$(./obj_dir/tb_tlb 2>&1) || true
echo "$output"

if grep -qx "Simulation completed successfully" <<< "$output"; then
    exit 0
else
    exit 1
fi
